//--- image_buffer_consts.svh
// ======================================
// sizes and register map of the frame
// buffer. included by the package and by
// every module that needs a width or an
// APB register offset.
// ======================================

`ifndef IMAGE_BUFFER_CONSTS_SVH
`define IMAGE_BUFFER_CONSTS_SVH

// RAM geometry. 4096 words of 32 bits.
`define IMG_WORD_ADDR_W 12

// camera side addresses bytes, two more bits than a word address.
`define IMG_BYTE_ADDR_W 14

// reader side addresses pixels, wide enough for four grey pixels per word.
`define IMG_PIX_IDX_W   14

// APB control port.
`define APB_ADDR_W      4

`define REG_CTRL        4'h0 // bit 0 capture enable, bit 1 format.
`define REG_WORD_COUNT  4'h4 // committed words, write clears.
`define REG_LAST_ADDR   4'h8 // word address of the last commit.

`endif

//--- image_buffer_pkg.sv
// ======================================
// shared types of the frame buffer: the
// configuration, camera, RAM, APB and
// reader structs and the RAM word union.
// ======================================

`include "image_buffer_consts.svh"

package image_buffer_pkg;

    typedef enum logic {
        FMT_GRAY8  = 1'b0, // four 8-bit pixels per word.
        FMT_RGB565 = 1'b1  // two 16-bit pixels per word.
    } pixel_format_t;

    typedef struct packed {
        logic          capture_enable;
        pixel_format_t format;
    } buffer_cfg_t;

    typedef struct packed {
        logic                        valid;
        logic [`IMG_BYTE_ADDR_W-1:0] byte_addr;
        logic [7:0]                  data;
    } cam_byte_t;

    typedef struct packed {
        logic                        we;
        logic [`IMG_WORD_ADDR_W-1:0] word_addr;
        logic [31:0]                 wdata;
    } ram_req_t;

    // one stored word, seen as bytes or as halfwords.
    // lane 0 is the lowest byte address.
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } ram_word_u;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [`IMG_PIX_IDX_W-1:0] pix_idx;
    } rd_req_t;

endpackage

//--- word_ram.sv
// ======================================
// single-port 32-bit word RAM, inferred.
// one cycle read latency, write-first,
// read register cleared on reset.
// ======================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module word_ram (
    input  logic                        clock_in,
    input  logic                        read_reset_n_in,
    input  logic [`IMG_WORD_ADDR_W-1:0] address,
    input  logic [31:0]                 write_data,
    input  logic                        write_enable,
    output logic [31:0]                 read_data
);

    localparam int DEPTH = 1 << `IMG_WORD_ADDR_W;

    logic [31:0] mem [0:DEPTH-1];

    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            mem[address] <= write_data;
        end
    end

    // a write shows its own data on the read port.
    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            read_data <= '0;
        end else if (write_enable) begin
            read_data <= write_data;
        end else begin
            read_data <= mem[address];
        end
    end

endmodule

//--- pixel_packer.sv
// ======================================
// packs camera bytes into 32-bit words.
// a byte on lane 3 closes the word and
// issues one registered RAM write plus a
// commit pulse for the control block.
// ======================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module pixel_packer (
    input  logic                        clock_in,
    input  logic                        read_reset_n_in,
    input  image_buffer_pkg::buffer_cfg_t cfg,
    input  image_buffer_pkg::cam_byte_t   cam,
    output image_buffer_pkg::ram_req_t    wr_req,
    output logic                        word_commit
);

    import image_buffer_pkg::*;

    logic                        byte_take;
    logic [1:0]                  lane;
    ram_word_u                   asm_q;      // word under assembly.
    ram_word_u                   asm_next;
    logic                        wr_we_q;
    logic [`IMG_WORD_ADDR_W-1:0] wr_addr_q;
    logic [31:0]                 wr_data_q;

    assign byte_take = cam.valid && cfg.capture_enable; // dropped when capture is off.
    assign lane      = cam.byte_addr[1:0];

    // the new byte is merged here so lane 3 can be written straight away.
    always_comb begin
        asm_next = asm_q;
        if (byte_take) begin
            asm_next.bytes[lane] = cam.data;
        end
    end

    always_ff @(posedge clock_in) begin
        asm_q <= asm_next;
        if (byte_take && lane == 2'd3) begin
            wr_addr_q <= cam.byte_addr[`IMG_BYTE_ADDR_W-1:2];
            wr_data_q <= asm_next;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            wr_we_q <= 1'b0;
        end else begin
            wr_we_q <= byte_take && lane == 2'd3; // single cycle pulse.
        end
    end

    always_comb begin
        wr_req.we        = wr_we_q;
        wr_req.word_addr = wr_addr_q;
        wr_req.wdata     = wr_data_q;
    end

    // commit goes out with the write itself.
    assign word_commit = wr_we_q;

endmodule

//--- pixel_unpacker.sv
// ======================================
// owns the RAM port. packer writes win,
// the reader is held off by rd_ready.
// reads return a pixel two cycles after
// acceptance, in grey8 or rgb565 layout.
// ======================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module pixel_unpacker (
    input  logic                          clock_in,
    input  logic                          read_reset_n_in,
    input  image_buffer_pkg::buffer_cfg_t cfg,
    input  image_buffer_pkg::ram_req_t    wr_req,
    input  image_buffer_pkg::rd_req_t     rd_req,
    output logic                          rd_ready,
    output logic [`IMG_WORD_ADDR_W-1:0]   ram_addr,
    output logic [31:0]                   ram_wdata,
    output logic                          ram_we,
    input  logic [31:0]                   ram_rdata,
    output logic [15:0]                   pix_out,
    output logic                          pix_valid
);

    import image_buffer_pkg::*;

    logic                        rd_accept;
    logic [`IMG_WORD_ADDR_W-1:0] rd_word_addr;
    logic [1:0]                  rd_lane;
    logic                        s1_valid;   // RAM access in progress.
    logic [1:0]                  s1_lane;
    pixel_format_t               s1_format;
    ram_word_u                   word;

    assign rd_ready  = !wr_req.we;
    assign rd_accept = rd_req.valid && rd_ready;

    // index to word address and lane for the current format.
    always_comb begin
        if (cfg.format == FMT_RGB565) begin
            rd_word_addr = rd_req.pix_idx[`IMG_WORD_ADDR_W:1];
            rd_lane      = {1'b0, rd_req.pix_idx[0]};
        end else begin
            rd_word_addr = rd_req.pix_idx[`IMG_WORD_ADDR_W+1:2];
            rd_lane      = rd_req.pix_idx[1:0];
        end
    end

    assign ram_addr  = wr_req.we ? wr_req.word_addr : rd_word_addr; // write first.
    assign ram_wdata = wr_req.wdata;
    assign ram_we    = wr_req.we;

    always_ff @(posedge clock_in) begin
        s1_lane   <= rd_lane;
        s1_format <= cfg.format; // held per read, so a format change spares reads in flight.
        if (s1_format == FMT_RGB565) begin
            pix_out <= word.halves[s1_lane[0]];
        end else begin
            pix_out <= {8'h00, word.bytes[s1_lane]};
        end
    end

    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            s1_valid  <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            s1_valid  <= rd_accept;
            pix_valid <= s1_valid;
        end
    end

    assign word = ram_rdata;

endmodule

//--- buffer_ctrl_apb.sv
// ======================================
// APB slave of the frame buffer. holds
// capture enable and pixel format, counts
// committed words and keeps the address
// of the last one. no wait states.
// ======================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module buffer_ctrl_apb (
    input  logic                          clock_in,
    input  logic                          read_reset_n_in,
    input  image_buffer_pkg::apb_req_t    apb_req,
    output image_buffer_pkg::apb_rsp_t    apb_rsp,
    input  image_buffer_pkg::ram_req_t    wr_req,
    input  logic                          word_commit,
    output image_buffer_pkg::buffer_cfg_t cfg
);

    import image_buffer_pkg::*;

    logic                        apb_write;
    logic [31:0]                 word_count;
    logic [`IMG_WORD_ADDR_W-1:0] last_addr;
    logic [31:0]                 read_mux;

    // writes land at the end of the access phase.
    assign apb_write = apb_req.psel && apb_req.penable && apb_req.pwrite;

    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            cfg.capture_enable <= 1'b0;
            cfg.format         <= FMT_GRAY8;
        end else if (apb_write && apb_req.paddr == `REG_CTRL) begin
            cfg.capture_enable <= apb_req.pwdata[0];
            cfg.format         <= pixel_format_t'(apb_req.pwdata[1]);
        end
    end

    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            word_count <= '0;
        end else if (apb_write && apb_req.paddr == `REG_WORD_COUNT) begin
            // a commit in the clearing cycle still counts.
            word_count <= {31'd0, word_commit};
        end else if (word_commit) begin
            word_count <= word_count + 32'd1;
        end
    end

    always_ff @(posedge clock_in) begin
        if (!read_reset_n_in) begin
            last_addr <= '0;
        end else if (word_commit) begin
            last_addr <= wr_req.word_addr; // address of the write being committed.
        end
    end

    always_comb begin
        case (apb_req.paddr)
            `REG_CTRL: begin
                read_mux = {30'd0, cfg.format, cfg.capture_enable};
            end
            `REG_WORD_COUNT: begin
                read_mux = word_count;
            end
            `REG_LAST_ADDR: begin
                read_mux = {{(32-`IMG_WORD_ADDR_W){1'b0}}, last_addr};
            end
            default: begin
                read_mux = '0; // unmapped.
            end
        endcase
    end

    always_comb begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = read_mux;
    end

endmodule

//--- image_buffer_top.sv
// ======================================
// frame buffer top level. camera bytes in,
// APB control, pixel reads out through a
// ready/valid reader port.
// ======================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module image_buffer_top (
    input  logic                          clock_in,
    input  logic                          read_reset_n_in,
    input  image_buffer_pkg::cam_byte_t   cam,
    input  image_buffer_pkg::apb_req_t    apb_req,
    output image_buffer_pkg::apb_rsp_t    apb_rsp,
    input  image_buffer_pkg::rd_req_t     rd_req,
    output logic                          rd_ready,
    output logic [15:0]                   pix_out,
    output logic                          pix_valid
);

    import image_buffer_pkg::*;

    buffer_cfg_t                 cfg;
    ram_req_t                    wr_req;
    logic                        word_commit;
    logic [`IMG_WORD_ADDR_W-1:0] ram_addr;
    logic [31:0]                 ram_wdata;
    logic                        ram_we;
    logic [31:0]                 ram_rdata;

    buffer_ctrl_apb u_ctrl (
        .clock_in        (clock_in),
        .read_reset_n_in (read_reset_n_in),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .wr_req          (wr_req),
        .word_commit     (word_commit),
        .cfg             (cfg)
    );

    pixel_packer u_packer (
        .clock_in        (clock_in),
        .read_reset_n_in (read_reset_n_in),
        .cfg             (cfg),
        .cam             (cam),
        .wr_req          (wr_req),
        .word_commit     (word_commit)
    );

    pixel_unpacker u_unpacker (
        .clock_in        (clock_in),
        .read_reset_n_in (read_reset_n_in),
        .cfg             (cfg),
        .wr_req          (wr_req),
        .rd_req          (rd_req),
        .rd_ready        (rd_ready),
        .ram_addr        (ram_addr),
        .ram_wdata       (ram_wdata),
        .ram_we          (ram_we),
        .ram_rdata       (ram_rdata),
        .pix_out         (pix_out),
        .pix_valid       (pix_valid)
    );

    word_ram u_ram (
        .clock_in        (clock_in),
        .read_reset_n_in (read_reset_n_in),
        .address         (ram_addr),
        .write_data      (ram_wdata),
        .write_enable    (ram_we),
        .read_data       (ram_rdata)
    );

endmodule

//--- image_buffer_asserts.sv
// ========================================
// handshake checks on the frame buffer
// top level, attached by bind at the end
// of this file.
// ========================================

`timescale 1ns/100ps

module image_buffer_asserts (
    input logic                       clock_in,
    input logic                       read_reset_n_in,
    input image_buffer_pkg::apb_req_t apb_req,
    input image_buffer_pkg::apb_rsp_t apb_rsp,
    input image_buffer_pkg::rd_req_t  rd_req,
    input logic                       rd_ready,
    input logic                       pix_valid,
    input logic                       ram_we
);

    logic rd_accept;

    assign rd_accept = rd_req.valid && rd_ready;

    // fixed two cycle read latency.
    pix_valid_after_accept: assert property (
        @(posedge clock_in) disable iff (!read_reset_n_in)
        pix_valid == $past(rd_accept, 2)
    ) else $error("pix_valid does not follow an accepted read by two cycles");

    ready_low_on_write: assert property (
        @(posedge clock_in) disable iff (!read_reset_n_in)
        ram_we |-> !rd_ready
    ) else $error("rd_ready high while the RAM is written");

    pready_in_access: assert property (
        @(posedge clock_in) disable iff (!read_reset_n_in)
        (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
    ) else $error("pready low in an APB access phase");

    write_single_cycle: assert property (
        @(posedge clock_in) disable iff (!read_reset_n_in)
        ram_we |=> !ram_we
    ) else $error("RAM write enable high for two cycles in a row");

endmodule

bind image_buffer_top image_buffer_asserts u_asserts (
    .clock_in        (clock_in),
    .read_reset_n_in (read_reset_n_in),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .rd_req          (rd_req),
    .rd_ready        (rd_ready),
    .pix_valid       (pix_valid),
    .ram_we          (ram_we)
);

//--- image_buffer_tb.sv
// ========================================
// testbench of the frame buffer. drives
// APB, camera bytes and pixel reads and
// checks each pixel against a byte model.
// built and run by run.sh from all.f.
// ========================================

`timescale 1ns/100ps

`include "image_buffer_consts.svh"

module image_buffer_tb;

    import image_buffer_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int DRIVE_DELAY     = 1; // inputs change this long after the rising edge.
    localparam int RESET_CYCLES    = 4;
    localparam int GRAY_WORDS      = 32;
    localparam int DROP_BYTES      = 16;
    localparam int COLLIDE_WORDS   = 16;
    localparam int COLLIDE_READS   = 64;
    localparam int APB_OPS         = 20;
    localparam int TRANSFERS       = GRAY_WORDS * 4 * 2 + GRAY_WORDS * 2 + DROP_BYTES * 3
                                     + COLLIDE_WORDS * 4 + COLLIDE_READS + APB_OPS;
    localparam int WATCHDOG_CYCLES = TRANSFERS * 20 + 200;
    localparam int MODEL_BYTES     = 1 << `IMG_BYTE_ADDR_W;

    logic                      clock_in = 1'b0;
    logic                      read_reset_n_in;
    cam_byte_t                 cam;
    apb_req_t                  apb_req;
    apb_rsp_t                  apb_rsp;
    rd_req_t                   rd_req;
    logic                      rd_ready;
    logic [15:0]               pix_out;
    logic                      pix_valid;

    logic [7:0]                model_bytes [0:MODEL_BYTES-1]; // RAM contents by byte address.
    logic [7:0]                asm_model [0:3];               // word being packed.
    logic [15:0]               expected_q [$];
    logic [15:0]               exp_pix;
    logic [31:0]               rng_state;
    logic [31:0]               rd_data;
    logic [31:0]               collide_data [0:COLLIDE_WORDS-1];
    logic [`IMG_PIX_IDX_W-1:0] collide_idx [0:COLLIDE_READS-1];
    pixel_format_t             cur_format;
    logic                      capture_on;
    int                        commit_count;
    int                        last_commit_addr;

    image_buffer_top uut (
        .clock_in        (clock_in),
        .read_reset_n_in (read_reset_n_in),
        .cam             (cam),
        .apb_req         (apb_req),
        .apb_rsp         (apb_rsp),
        .rd_req          (rd_req),
        .rd_ready        (rd_ready),
        .pix_out         (pix_out),
        .pix_valid       (pix_valid)
    );

    always #(CLK_PERIOD / 2) clock_in = ~clock_in;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %0t: %s is 0x%0h, expected 0x%0h",
                                    $time, what, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // grey pixel n is byte n. rgb565 pixel n is bytes 2n (low) and 2n+1 (high).
    function automatic logic [15:0] expected_pixel(input pixel_format_t fmt,
                                                   input logic [`IMG_PIX_IDX_W-1:0] idx);
        logic [`IMG_BYTE_ADDR_W-1:0] base;
        if (fmt == FMT_RGB565) begin
            base = {idx[`IMG_PIX_IDX_W-2:0], 1'b0};
            return {model_bytes[base + 14'd1], model_bytes[base]};
        end
        return {8'h00, model_bytes[idx]};
    endfunction

    task automatic step();
        @(posedge clock_in);
        #DRIVE_DELAY;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        step();
        apb_req.penable = 1'b1; // access phase.
        @(negedge clock_in);
        while (!apb_rsp.pready) begin
            @(negedge clock_in);
        end
        step();
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, output logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        step();
        apb_req.penable = 1'b1;
        @(negedge clock_in);
        while (!apb_rsp.pready) begin
            @(negedge clock_in);
        end
        data = apb_rsp.prdata;
        step();
        apb_req = '0;
    endtask

    task automatic set_ctrl(input logic capture, input pixel_format_t fmt);
        apb_write(`REG_CTRL, {30'd0, fmt, capture});
        capture_on = capture;
        cur_format = fmt;
    endtask

    // one byte per cycle. the model takes it at the sampling edge.
    task automatic send_cam_byte(input logic [`IMG_BYTE_ADDR_W-1:0] addr, input logic [7:0] data);
        int k;
        cam = '{valid: 1'b1, byte_addr: addr, data: data};
        @(posedge clock_in);
        if (capture_on) begin
            asm_model[addr[1:0]] = data;
            if (addr[1:0] == 2'd3) begin
                for (k = 0; k < 4; k++) begin
                    model_bytes[{addr[`IMG_BYTE_ADDR_W-1:2], 2'(k)}] = asm_model[k];
                end
                commit_count++;
                last_commit_addr = int'(addr[`IMG_BYTE_ADDR_W-1:2]);
            end
        end
        #DRIVE_DELAY;
        cam.valid = 1'b0;
    endtask

    task automatic send_word(input logic [`IMG_WORD_ADDR_W-1:0] word_addr, input logic [31:0] data);
        int k;
        for (k = 0; k < 4; k++) begin
            send_cam_byte({word_addr, 2'(k)}, data[8*k +: 8]);
        end
    endtask

    task automatic request_pixel(input logic [`IMG_PIX_IDX_W-1:0] idx);
        logic accepted;
        accepted = 1'b0;
        rd_req = '{valid: 1'b1, pix_idx: idx};
        while (!accepted) begin
            @(negedge clock_in);
            if (rd_ready) begin
                expected_q.push_back(expected_pixel(cur_format, idx));
                accepted = 1'b1;
            end
        end
        step();
        rd_req.valid = 1'b0;
    endtask

    task automatic wait_reads_done();
        while (expected_q.size() != 0) begin
            @(posedge clock_in);
        end
        step();
    endtask

    // pixels come back in request order.
    always @(negedge clock_in) begin
        if (read_reset_n_in && pix_valid) begin
            if (expected_q.size() == 0) begin
                stop_on_error("a pixel came back with no read outstanding");
            end else begin
                exp_pix = expected_q.pop_front();
                check_value({16'd0, pix_out}, {16'd0, exp_pix}, "pixel");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock_in);
        stop_on_error("timeout, the test sequence did not finish in time");
    end

    initial begin : main_sequence
        int i;
        int j;
        rng_state        = 32'd24649;
        read_reset_n_in  = 1'b0;
        cam              = '0;
        apb_req          = '0;
        rd_req           = '0;
        cur_format       = FMT_GRAY8;
        capture_on       = 1'b0;
        commit_count     = 0;
        last_commit_addr = 0;
        for (i = 0; i < MODEL_BYTES; i++) begin
            model_bytes[i] = 8'h00;
        end
        for (i = 0; i < 4; i++) begin
            asm_model[i] = 8'h00;
        end
        repeat (RESET_CYCLES) @(posedge clock_in);
        #DRIVE_DELAY;
        read_reset_n_in = 1'b1;
        step();

        apb_read(`REG_CTRL, rd_data);
        check_value(rd_data, 32'd0, "REG_CTRL after reset");
        apb_read(`REG_WORD_COUNT, rd_data);
        check_value(rd_data, 32'd0, "REG_WORD_COUNT after reset");
        apb_read(`REG_LAST_ADDR, rd_data);
        check_value(rd_data, 32'd0, "REG_LAST_ADDR after reset");
        // each bit on its own so a swapped field shows up.
        apb_write(`REG_CTRL, 32'h1);
        apb_read(`REG_CTRL, rd_data);
        check_value(rd_data, 32'h1, "REG_CTRL read back");
        apb_write(`REG_CTRL, 32'h2);
        apb_read(`REG_CTRL, rd_data);
        check_value(rd_data, 32'h2, "REG_CTRL read back");

        // grey capture followed by every pixel back to back.
        set_ctrl(1'b1, FMT_GRAY8);
        for (i = 0; i < GRAY_WORDS; i++) begin
            send_word(`IMG_WORD_ADDR_W'(i), next_random());
        end
        for (i = 0; i < GRAY_WORDS * 4; i++) begin
            request_pixel(`IMG_PIX_IDX_W'(i));
        end
        wait_reads_done();

        set_ctrl(1'b1, FMT_RGB565); // same words as halfwords.
        for (i = 0; i < GRAY_WORDS * 2; i++) begin
            request_pixel(`IMG_PIX_IDX_W'(i));
        end
        wait_reads_done();

        // with capture off these bytes never reach the RAM.
        set_ctrl(1'b0, FMT_RGB565);
        for (i = 0; i < DROP_BYTES; i++) begin
            send_cam_byte(`IMG_BYTE_ADDR_W'(i), 8'(next_random()));
        end
        for (i = 0; i < DROP_BYTES / 2; i++) begin
            request_pixel(`IMG_PIX_IDX_W'(i));
        end
        wait_reads_done();
        set_ctrl(1'b0, FMT_GRAY8);
        for (i = 0; i < DROP_BYTES; i++) begin
            request_pixel(`IMG_PIX_IDX_W'(i));
        end
        wait_reads_done();

        apb_read(`REG_WORD_COUNT, rd_data);
        check_value(rd_data, 32'(commit_count), "REG_WORD_COUNT");
        apb_read(`REG_LAST_ADDR, rd_data);
        check_value(rd_data, 32'(last_commit_addr), "REG_LAST_ADDR");
        apb_write(`REG_WORD_COUNT, 32'd0);
        commit_count = 0;
        apb_read(`REG_WORD_COUNT, rd_data);
        check_value(rd_data, 32'd0, "REG_WORD_COUNT after clear");

        // overwrite words while reads run so writes steal the RAM port.
        for (i = 0; i < COLLIDE_WORDS; i++) begin
            collide_data[i] = next_random();
        end
        for (i = 0; i < COLLIDE_READS; i++) begin
            collide_idx[i] = `IMG_PIX_IDX_W'(next_random() % (GRAY_WORDS * 4));
        end
        set_ctrl(1'b1, FMT_GRAY8);
        fork
            begin
                for (i = 0; i < COLLIDE_WORDS; i++) begin
                    send_word(`IMG_WORD_ADDR_W'(i), collide_data[i]);
                end
            end
            begin
                for (j = 0; j < COLLIDE_READS; j++) begin
                    request_pixel(collide_idx[j]);
                end
            end
        join
        wait_reads_done();
        apb_read(`REG_WORD_COUNT, rd_data);
        check_value(rd_data, 32'(commit_count), "REG_WORD_COUNT after collisions");
        apb_read(`REG_LAST_ADDR, rd_data);
        check_value(rd_data, 32'(last_commit_addr), "REG_LAST_ADDR after collisions");

        $display("TEST OK");
        $finish;
    end

endmodule

//--- all.f
+incdir+.
image_buffer_pkg.sv
word_ram.sv
pixel_packer.sv
pixel_unpacker.sv
buffer_ctrl_apb.sv
image_buffer_top.sv
image_buffer_asserts.sv
image_buffer_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the frame buffer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module image_buffer_tb -o image_buffer_sim

# the simulator exits non-zero on a fatal error, the log decides.
./obj_dir/image_buffer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
